//--- vlog.f
src/hacd_pkg.sv
src/hawk_ctrl_unit.sv
src/hawk_cpu_stall.sv
src/hawk_mem_mux.sv
src/hacd_core.sv
sim/tb_hacd_checker.sv
sim/tb_hacd_core.sv

//--- Makefile
# Verilator build for the hacd core and its testbench

VERILATOR ?= verilator
FILELIST  ?= vlog.f
TB_TOP    ?= tb_hacd_core
RTL_TOP   ?= hacd_core
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TB_TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TEST PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- sim/tb_hacd_core.sv
// hacd core testbench top
// clock, reset, memory controller model with random back-pressure,
// table of cpu requests driven in a loop on the falling edge

`timescale 1ns/10ps

module tb_hacd_core;
   import hacd_pkg::*;

   localparam int MEM_LAT   = 3;     // read latency of the mc model
   localparam int TIMEOUT   = 200;   // cycles per wait loop
   localparam int N_TESTS   = 15;
   localparam int P1_LAST   = 11;    // last row of the active phase
   localparam int QUIET_CYC = 40;    // bypass watch window

   logic clk_i = 1'b0;
   logic reset_i, hawk_reg_inactive_i;
   logic [1:0] hawk_sw_ctrl_i;
   logic cpu_req_valid_i, cpu_req_ready_o, cpu_rsp_valid_o;
   mem_op_e cpu_req_op_i, mc_req_op_o;
   logic [ADDR_W-1:0] cpu_req_addr_i, mc_req_addr_o;
   logic [DATA_W-1:0] cpu_req_wdata_i, cpu_rsp_rdata_o, mc_req_wdata_o, mc_rsp_rdata_i;
   logic mc_req_valid_o, mc_req_ready_i, mc_rsp_valid_i, init_done_o, illegal_access_o;

   // stimulus table
   string             t_name  [N_TESTS];
   mem_op_e           t_op    [N_TESTS];
   logic [ADDR_W-1:0] t_addr  [N_TESTS];
   logic [DATA_W-1:0] t_wdata [N_TESTS];
   logic [DATA_W-1:0] t_exp   [N_TESTS];   // rdata or illegal flag for writes

   // mc model state
   logic [DATA_W-1:0] mem [logic [ADDR_W-1:0]];
   logic [DATA_W-1:0] rsp_data_q [$];
   int                rsp_due_q [$];
   int                cyc = 0;
   logic [31:0]       rng = 32'hc43e_0f1e;

   always #4 clk_i = ~clk_i;   // 8 ns period

   hacd_core u_dut (.*);

   tb_hacd_checker u_chk (
      .clk_i, .reset_i,
      .bypass_i        (hawk_sw_ctrl_i[0]),
      .cpu_req_valid_i, .cpu_req_ready_i (cpu_req_ready_o), .cpu_req_op_i,
      .cpu_rsp_valid_i (cpu_rsp_valid_o), .cpu_rsp_rdata_i (cpu_rsp_rdata_o),
      .mc_req_valid_i  (mc_req_valid_o), .mc_req_ready_i, .mc_req_op_i (mc_req_op_o),
      .mc_req_addr_i   (mc_req_addr_o), .mc_req_wdata_i (mc_req_wdata_o),
      .init_done_i     (init_done_o), .illegal_access_i (illegal_access_o)
   );

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // unwritten words show every address bit
   function automatic logic [DATA_W-1:0] fill_word(input logic [ADDR_W-1:0] a);
      return {a ^ 32'h5a5a_5a5a, ~a};
   endfunction

   //////////////////////////////////////////////////
   // memory controller model
   //////////////////////////////////////////////////
   always @(posedge clk_i) begin
      cyc = cyc + 1;
      if (!reset_i && mc_req_valid_o && mc_req_ready_i) begin
         if (mc_req_op_o == OP_WRITE) begin
            mem[mc_req_addr_o] = mc_req_wdata_o;
         end else begin
            rsp_data_q.push_back(mem.exists(mc_req_addr_o) ?
                                 mem[mc_req_addr_o] : fill_word(mc_req_addr_o));
            rsp_due_q.push_back(cyc + MEM_LAT);
         end
      end
   end

   always @(negedge clk_i) begin
      rng = xorshift32(rng);
      mc_req_ready_i <= (rng[1:0] != 2'b00);   // ready about 3 of 4 cycles
      mc_rsp_valid_i <= 1'b0;
      if (rsp_due_q.size() != 0 && rsp_due_q[0] <= cyc) begin
         mc_rsp_valid_i <= 1'b1;   // in order and one per cycle
         mc_rsp_rdata_i <= rsp_data_q.pop_front();
         void'(rsp_due_q.pop_front());
      end
   end

   task automatic set_row(input int i, input string n, input mem_op_e op,
                          input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] wd,
                          input logic [DATA_W-1:0] ex);
      t_name[i] = n;
      t_op[i] = op;
      t_addr[i] = a;
      t_wdata[i] = wd;
      t_exp[i] = ex;
   endtask

   task automatic abort_run(input string why);
      $display("timeout: %s", why);
      u_chk.print_counts();
      $display("TEST FAIL");
      $finish;
   endtask

   // one table row held until the cpu handshake
   task automatic run_row(input int i, input bit held);
      int  n;
      logic acc;
      if (t_op[i] == OP_READ && !held) u_chk.expect_read(t_name[i], t_exp[i]);
      @(negedge clk_i);
      cpu_req_valid_i = 1'b1;
      cpu_req_op_i    = t_op[i];
      cpu_req_addr_i  = t_addr[i];
      cpu_req_wdata_i = t_wdata[i];
      n = 0;
      do begin
         @(posedge clk_i);
         acc = cpu_req_valid_i && cpu_req_ready_o;
         n++;
      end while (!acc && n < TIMEOUT);
      if (!acc) begin
         abort_run({"cpu request not accepted in ", t_name[i]});
      end else begin
         @(negedge clk_i);
         cpu_req_valid_i = 1'b0;
         if (t_op[i] == OP_WRITE) u_chk.end_write(t_name[i], t_exp[i][0]);
      end
   endtask

   task automatic drain_reads();
      int n;
      n = 0;
      while (u_chk.rd_name.size() != 0 && n < TIMEOUT) begin
         @(posedge clk_i);
         n++;
      end
      if (u_chk.rd_name.size() != 0) abort_run("read responses missing");
   endtask

   task automatic wait_init();
      int n;
      n = 0;
      while (!init_done_o && n < TIMEOUT) begin
         @(posedge clk_i);
         n++;
      end
      if (!init_done_o) abort_run("free-list build never finished");
   endtask

   //////////////////////////////////////////////////
   // main sequence
   //////////////////////////////////////////////////
   initial begin
      set_row(0,  "rd_entry0",  OP_READ,  32'h1000, '0, 64'd1);
      set_row(1,  "rd_entry7",  OP_READ,  32'h1038, '0, 64'd8);
      set_row(2,  "rd_entry15", OP_READ,  32'h1078, '0, NULL_PTR);
      set_row(3,  "wr_a",       OP_WRITE, 32'h2000, 64'h1111, 64'd0);
      set_row(4,  "wr_b",       OP_WRITE, 32'h2008, 64'h2222, 64'd0);
      set_row(5,  "rd_a",       OP_READ,  32'h2000, '0, 64'h1111);   // reads overlap in flight
      set_row(6,  "rd_b",       OP_READ,  32'h2008, '0, 64'h2222);
      set_row(7,  "rd_a_again", OP_READ,  32'h2000, '0, 64'h1111);
      set_row(8,  "wr_a_new",   OP_WRITE, 32'h2000, 64'h3333, 64'd0);
      set_row(9,  "rd_a_new",   OP_READ,  32'h2000, '0, 64'h3333);
      set_row(10, "wr_table",   OP_WRITE, 32'h1010, 64'hdead, 64'd1);   // dropped
      set_row(11, "rd_entry2",  OP_READ,  32'h1010, '0, 64'd3);
      set_row(12, "by_wr_table", OP_WRITE, 32'h1010, 64'hbeef, 64'd0);
      set_row(13, "by_rd_table", OP_READ,  32'h1010, '0, 64'hbeef);
      set_row(14, "by_rd_a",     OP_READ,  32'h2000, '0, 64'h3333);

      reset_i = 1'b1;
      hawk_sw_ctrl_i = 2'b00;
      hawk_reg_inactive_i = 1'b0;
      cpu_req_valid_i = 1'b0;
      cpu_req_op_i = OP_READ;
      cpu_req_addr_i = '0;
      cpu_req_wdata_i = '0;
      mc_req_ready_i = 1'b0;
      mc_rsp_valid_i = 1'b0;
      mc_rsp_rdata_i = '0;

      // cpu read raised in reset and held through the build
      @(negedge clk_i);
      u_chk.expect_read(t_name[0], t_exp[0]);
      cpu_req_valid_i = 1'b1;
      cpu_req_op_i    = t_op[0];
      cpu_req_addr_i  = t_addr[0];
      repeat (4) @(negedge clk_i);
      reset_i = 1'b0;
      wait_init();
      u_chk.check_build();
      for (int i = 0; i <= P1_LAST; i++) run_row(i, i == 0);
      drain_reads();

      // second reset into bypass
      @(negedge clk_i);
      hawk_sw_ctrl_i = 2'b01;
      reset_i = 1'b1;
      repeat (5) @(negedge clk_i);
      reset_i = 1'b0;
      for (int n = 0; n < QUIET_CYC && !init_done_o; n++) @(posedge clk_i);
      for (int i = P1_LAST + 1; i < N_TESTS; i++) run_row(i, 1'b0);
      drain_reads();

      u_chk.print_counts();
      if (u_chk.n_fail == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

//--- sim/tb_hacd_checker.sv
// hacd core checker
// watches cpu and mc ports, follows the list build against the
// table layout, compares read data and the illegal flag per test

`timescale 1ns/10ps

module tb_hacd_checker
   import hacd_pkg::*;
(
   input logic              clk_i,
   input logic              reset_i,
   input logic              bypass_i,
   input logic              cpu_req_valid_i,
   input logic              cpu_req_ready_i,
   input mem_op_e           cpu_req_op_i,
   input logic              cpu_rsp_valid_i,
   input logic [DATA_W-1:0] cpu_rsp_rdata_i,
   input logic              mc_req_valid_i,
   input logic              mc_req_ready_i,
   input mem_op_e           mc_req_op_i,
   input logic [ADDR_W-1:0] mc_req_addr_i,
   input logic [DATA_W-1:0] mc_req_wdata_i,
   input logic              init_done_i,
   input logic              illegal_access_i
);

   int                n_pass = 0;
   int                n_fail = 0;
   int                build_idx = 0;      // next expected list entry
   bit                bypass_done_err = 0;
   string             rd_name [$];        // reads in flight oldest first
   logic [DATA_W-1:0] rd_exp  [$];
   logic              mc_wr;
   logic [ADDR_W-1:0] exp_a;
   logic [DATA_W-1:0] exp_w;

   task automatic expect_read(input string name, input logic [DATA_W-1:0] exp);
      rd_name.push_back(name);
      rd_exp.push_back(exp);
   endtask

   task automatic end_write(input string name, input logic exp_ill);
      if (illegal_access_i !== exp_ill) begin
         $display("Fail %s expected %0b actual %0b", name, exp_ill, illegal_access_i);
         n_fail++;
      end else begin
         $display("pass %s", name);
         n_pass++;
      end
   endtask

   // every list entry written once
   task automatic check_build();
      if (build_idx != LIST_ENTRIES) begin
         $display("Fail list_build expected %0d entries actual %0d", LIST_ENTRIES,
                  build_idx);
         n_fail++;
      end else begin
         $display("pass list_build");
         n_pass++;
      end
   endtask

   task automatic print_counts();
      $display("tests passed %0d failed %0d", n_pass, n_fail);
   endtask

   assign mc_wr = mc_req_valid_i && mc_req_ready_i && (mc_req_op_i == OP_WRITE);

   //////////////////////////////////////////////////
   // per-cycle monitor
   //////////////////////////////////////////////////
   always @(posedge clk_i) begin
      if (reset_i) begin
         build_idx = 0;
      end else begin
         if (cpu_rsp_valid_i) begin
            if (rd_name.size() == 0) begin
               $display("error: read response with no read outstanding");
               n_fail++;
            end else if (cpu_rsp_rdata_i !== rd_exp[0]) begin
               $display("Fail %s expected %h actual %h", rd_name[0], rd_exp[0],
                        cpu_rsp_rdata_i);
               n_fail++;
            end else begin
               $display("pass %s", rd_name[0]);
               n_pass++;
            end
            if (rd_name.size() != 0) begin
               void'(rd_name.pop_front());
               void'(rd_exp.pop_front());
            end
         end
         // cpu held off for the whole build
         if (!bypass_i && !init_done_i && cpu_req_valid_i && cpu_req_ready_i) begin
            $display("error: cpu request accepted during list build");
            n_fail++;
         end
         if (!bypass_i && !init_done_i && mc_wr) begin
            exp_a = LIST_BASE + ADDR_W'(build_idx * ENTRY_BYTES);
            exp_w = (build_idx == LIST_ENTRIES - 1) ? NULL_PTR : DATA_W'(build_idx + 1);
            if (build_idx >= LIST_ENTRIES) begin
               $display("error: list write past the last entry");
               n_fail++;
            end else if (mc_req_addr_i !== exp_a || mc_req_wdata_i !== exp_w) begin
               $display("Fail list_build expected %h %h actual %h %h", exp_a, exp_w,
                        mc_req_addr_i, mc_req_wdata_i);
               n_fail++;
            end
            build_idx++;
         end
         if (bypass_i && init_done_i && !bypass_done_err) begin
            $display("error: init done raised in bypass");
            bypass_done_err = 1;
            n_fail++;
         end
         if (bypass_i && mc_wr && !(cpu_req_valid_i && cpu_req_op_i == OP_WRITE) &&
             mc_req_addr_i >= LIST_BASE && mc_req_addr_i < LIST_END) begin
            $display("error: table write without a cpu write in bypass");
            n_fail++;
         end
      end
   end

endmodule

//--- src/hacd_core.sv
// hacd core top
// control unit builds the free list, cpu stall gate holds and
// guards cpu traffic, memory mux joins both onto the mc port

`timescale 1ns/10ps

module hacd_core
   import hacd_pkg::*;
(
   input  logic              clk_i,
   input  logic              reset_i,
   input  logic [1:0]        hawk_sw_ctrl_i,
   input  logic              hawk_reg_inactive_i,

   // cpu side
   input  logic              cpu_req_valid_i,
   output logic              cpu_req_ready_o,
   input  mem_op_e           cpu_req_op_i,
   input  logic [ADDR_W-1:0] cpu_req_addr_i,
   input  logic [DATA_W-1:0] cpu_req_wdata_i,
   output logic              cpu_rsp_valid_o,
   output logic [DATA_W-1:0] cpu_rsp_rdata_o,

   // memory controller side
   output logic              mc_req_valid_o,
   input  logic              mc_req_ready_i,
   output mem_op_e           mc_req_op_o,
   output logic [ADDR_W-1:0] mc_req_addr_o,
   output logic [DATA_W-1:0] mc_req_wdata_o,
   input  logic              mc_rsp_valid_i,
   input  logic [DATA_W-1:0] mc_rsp_rdata_i,

   output logic              init_done_o,
   output logic              illegal_access_o
);

   // hawk master
   logic              hk_req_valid;
   logic              hk_req_ready;
   mem_op_e           hk_req_op;
   logic [ADDR_W-1:0] hk_req_addr;
   logic [DATA_W-1:0] hk_req_wdata;

   // gated cpu master
   logic              st_req_valid;
   logic              st_req_ready;
   mem_op_e           st_req_op;
   logic [ADDR_W-1:0] st_req_addr;
   logic [DATA_W-1:0] st_req_wdata;

   logic              hawk_busy;       // build running, cpu held
   logic              table_protect;

   //////////////////////////////////////////////////
   // instances
   //////////////////////////////////////////////////
   hawk_ctrl_unit u_ctrl_unit (
      .clk_i, .reset_i, .hawk_sw_ctrl_i, .hawk_reg_inactive_i,
      .hk_req_valid_o (hk_req_valid),
      .hk_req_op_o    (hk_req_op),
      .hk_req_addr_o  (hk_req_addr),
      .hk_req_wdata_o (hk_req_wdata),
      .hk_req_ready_i (hk_req_ready),
      .hawk_busy_o    (hawk_busy),
      .table_protect_o(table_protect),
      .init_done_o
   );

   hawk_cpu_stall u_cpu_stall (
      .clk_i, .reset_i,
      .hawk_busy_i    (hawk_busy),
      .table_protect_i(table_protect),
      .cpu_req_valid_i, .cpu_req_ready_o, .cpu_req_op_i, .cpu_req_addr_i, .cpu_req_wdata_i,
      .st_req_valid_o (st_req_valid),
      .st_req_op_o    (st_req_op),
      .st_req_addr_o  (st_req_addr),
      .st_req_wdata_o (st_req_wdata),
      .st_req_ready_i (st_req_ready),
      .illegal_access_o
   );

   hawk_mem_mux u_mem_mux (
      .clk_i, .reset_i,
      .hawk_busy_i    (hawk_busy),
      .hk_req_valid_i (hk_req_valid),
      .hk_req_ready_o (hk_req_ready),
      .hk_req_op_i    (hk_req_op),
      .hk_req_addr_i  (hk_req_addr),
      .hk_req_wdata_i (hk_req_wdata),
      .st_req_valid_i (st_req_valid),
      .st_req_ready_o (st_req_ready),
      .st_req_op_i    (st_req_op),
      .st_req_addr_i  (st_req_addr),
      .st_req_wdata_i (st_req_wdata),
      .mc_req_valid_o, .mc_req_ready_i, .mc_req_op_o, .mc_req_addr_o, .mc_req_wdata_o,
      .mc_rsp_valid_i, .mc_rsp_rdata_i,
      .cpu_rsp_valid_o, .cpu_rsp_rdata_o
   );

endmodule

//--- src/hawk_mem_mux.sv
// two-master memory mux
// joins the hawk request and the gated cpu request onto the single
// memory controller port. owner select is registered and only moves
// with no reads in flight. read responses go back to the cpu in order

`timescale 1ns/10ps

module hawk_mem_mux
   import hacd_pkg::*;
(
   input  logic              clk_i,
   input  logic              reset_i,
   input  logic              hawk_busy_i,

   // master 0, hawk
   input  logic              hk_req_valid_i,
   output logic              hk_req_ready_o,
   input  mem_op_e           hk_req_op_i,
   input  logic [ADDR_W-1:0] hk_req_addr_i,
   input  logic [DATA_W-1:0] hk_req_wdata_i,

   // master 1, gated cpu
   input  logic              st_req_valid_i,
   output logic              st_req_ready_o,
   input  mem_op_e           st_req_op_i,
   input  logic [ADDR_W-1:0] st_req_addr_i,
   input  logic [DATA_W-1:0] st_req_wdata_i,

   // memory controller
   output logic              mc_req_valid_o,
   input  logic              mc_req_ready_i,
   output mem_op_e           mc_req_op_o,
   output logic [ADDR_W-1:0] mc_req_addr_o,
   output logic [DATA_W-1:0] mc_req_wdata_o,
   input  logic              mc_rsp_valid_i,
   input  logic [DATA_W-1:0] mc_rsp_rdata_i,

   // read response, cpu is the only reader
   output logic              cpu_rsp_valid_o,
   output logic [DATA_W-1:0] cpu_rsp_rdata_o
);

   logic               own_cpu_q;    // 0 hawk, 1 cpu
   logic [OUTST_W-1:0] outst_q;      // reads in flight
   logic               rd_full;
   logic               st_rd_hold;   // cpu read held, counter full
   logic               rd_fire;

   assign rd_full    = &outst_q;
   assign st_rd_hold = (st_req_op_i == OP_READ) && rd_full;

   //////////////////////////////////////////////////
   // request path
   //////////////////////////////////////////////////
   always_comb begin
      if (own_cpu_q) begin
         mc_req_valid_o = st_req_valid_i && !st_rd_hold;
         mc_req_op_o    = st_req_op_i;
         mc_req_addr_o  = st_req_addr_i;
         mc_req_wdata_o = st_req_wdata_i;
         st_req_ready_o = mc_req_ready_i && !st_rd_hold;
         hk_req_ready_o = 1'b0;
      end else begin
         mc_req_valid_o = hk_req_valid_i;
         mc_req_op_o    = hk_req_op_i;
         mc_req_addr_o  = hk_req_addr_i;
         mc_req_wdata_o = hk_req_wdata_i;
         st_req_ready_o = 1'b0;   // cpu waits for ownership
         hk_req_ready_o = mc_req_ready_i;
      end
   end

   // in-order responses, no back-pressure
   assign cpu_rsp_valid_o = mc_rsp_valid_i;
   assign cpu_rsp_rdata_o = mc_rsp_rdata_i;

   //////////////////////////////////////////////////
   // outstanding reads and owner select
   //////////////////////////////////////////////////
   assign rd_fire = mc_req_valid_o && mc_req_ready_i && (mc_req_op_o == OP_READ);

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         outst_q   <= '0;
         own_cpu_q <= 1'b0;   // hawk owns the port after reset
      end else begin
         case ({rd_fire, mc_rsp_valid_i})
            2'b10:   outst_q <= outst_q + 1'b1;
            2'b01:   outst_q <= outst_q - 1'b1;
            default: outst_q <= outst_q;   // both or neither
         endcase
         if (outst_q == '0) begin
            own_cpu_q <= !hawk_busy_i;   // hand over only when drained
         end
      end
   end

   a_no_stray_rsp : assert property (@(posedge clk_i) disable iff (reset_i)
      mc_rsp_valid_i |-> (outst_q != '0))
      else $error("mc response with no read outstanding");

   a_no_outst_ovf : assert property (@(posedge clk_i) disable iff (reset_i)
      rd_fire && !mc_rsp_valid_i |-> !rd_full)
      else $error("outstanding read counter overflow");

endmodule

//--- src/hawk_cpu_stall.sv
// cpu stall gate
// holds cpu requests off while hawk builds the free list, and once
// the table is guarded swallows cpu writes aimed at the table
// region, flagging them as illegal. reads always go through

`timescale 1ns/10ps

module hawk_cpu_stall
   import hacd_pkg::*;
(
   input  logic              clk_i,
   input  logic              reset_i,
   input  logic              hawk_busy_i,       // list build running
   input  logic              table_protect_i,   // table region guarded

   // cpu request in
   input  logic              cpu_req_valid_i,
   output logic              cpu_req_ready_o,
   input  mem_op_e           cpu_req_op_i,
   input  logic [ADDR_W-1:0] cpu_req_addr_i,
   input  logic [DATA_W-1:0] cpu_req_wdata_i,

   // gated request toward the mux
   output logic              st_req_valid_o,
   output mem_op_e           st_req_op_o,
   output logic [ADDR_W-1:0] st_req_addr_o,
   output logic [DATA_W-1:0] st_req_wdata_o,
   input  logic              st_req_ready_i,

   output logic              illegal_access_o   // sticky until reset
);

   logic in_table;     // cpu address inside the list region
   logic drop_wr;      // write to be swallowed
   logic illegal_q;

   //////////////////////////////////////////////////
   // table region decode
   //////////////////////////////////////////////////
   assign in_table = (cpu_req_addr_i >= LIST_BASE) && (cpu_req_addr_i < LIST_END);
   assign drop_wr  = table_protect_i && (cpu_req_op_i == OP_WRITE) && in_table;

   //////////////////////////////////////////////////
   // gate
   //////////////////////////////////////////////////
   // nothing passes during the build, dropped writes never reach the mux
   assign st_req_valid_o = cpu_req_valid_i && !hawk_busy_i && !drop_wr;
   assign st_req_op_o    = cpu_req_op_i;
   assign st_req_addr_o  = cpu_req_addr_i;
   assign st_req_wdata_o = cpu_req_wdata_i;

   // dropped write is taken at once, otherwise mux ready passes back
   always_comb begin
      if (hawk_busy_i) begin
         cpu_req_ready_o = 1'b0;
      end else if (drop_wr) begin
         cpu_req_ready_o = 1'b1;
      end else begin
         cpu_req_ready_o = st_req_ready_i;
      end
   end

   //////////////////////////////////////////////////
   // illegal access flag
   //////////////////////////////////////////////////
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         illegal_q <= 1'b0;
      end else if (cpu_req_valid_i && cpu_req_ready_o && drop_wr) begin
         illegal_q <= 1'b1;   // set on the swallowed write
      end
   end

   assign illegal_access_o = illegal_q;

   // guarded table never sees a cpu write past this gate
   a_no_table_wr : assert property (@(posedge clk_i) disable iff (reset_i)
      st_req_valid_o && st_req_ready_i && table_protect_i
      && (st_req_op_o == OP_WRITE) |->
         (st_req_addr_o < LIST_BASE) || (st_req_addr_o >= LIST_END))
      else $error("cpu write forwarded into guarded table region");

endmodule

//--- src/hawk_ctrl_unit.sv
// hawk control unit
// after reset decides between bypass and list build. in list build
// it writes the free list into the table region, entry k pointing
// at entry k+1 and the tail holding the null pointer. reports busy
// while the build runs and guards the table once it is done

`timescale 1ns/10ps

module hawk_ctrl_unit
   import hacd_pkg::*;
(
   input  logic              clk_i,
   input  logic              reset_i,
   input  logic [1:0]        hawk_sw_ctrl_i,        // bit 0 forces inactive
   input  logic              hawk_reg_inactive_i,   // register based inactive

   // hawk write request toward the mux
   output logic              hk_req_valid_o,
   output mem_op_e           hk_req_op_o,
   output logic [ADDR_W-1:0] hk_req_addr_o,
   output logic [DATA_W-1:0] hk_req_wdata_o,
   input  logic              hk_req_ready_i,

   // status
   output logic              hawk_busy_o,
   output logic              table_protect_o,
   output logic              init_done_o
);

   cu_state_e        state_q;
   cu_state_e        state_d;
   logic [IDX_W-1:0] idx_q;        // entry being written
   logic             last_entry;   // idx points at the tail
   logic             wr_fire;      // hawk write accepted by the mux
   logic             go_inactive;

   //////////////////////////////////////////////////
   // next state
   //////////////////////////////////////////////////
   assign go_inactive = hawk_sw_ctrl_i[0] || hawk_reg_inactive_i;
   assign last_entry  = (idx_q == IDX_W'(LIST_ENTRIES - 1));
   assign wr_fire     = hk_req_valid_o && hk_req_ready_i;

   always_comb begin
      state_d = state_q;
      case (state_q)
         CU_IDLE: begin
            // controls sampled once on the first cycle out of reset
            if (go_inactive) begin
               state_d = CU_BYPASS;
            end else begin
               state_d = CU_INIT_LIST;
            end
         end
         CU_INIT_LIST: begin
            if (wr_fire && last_entry) begin
               state_d = CU_ACTIVE;   // tail written
            end
         end
         CU_ACTIVE: state_d = CU_ACTIVE;    // only reset leaves
         CU_BYPASS: state_d = CU_BYPASS;
         default:   state_d = CU_IDLE;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         state_q <= CU_IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   //////////////////////////////////////////////////
   // entry counter
   //////////////////////////////////////////////////
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         idx_q <= '0;
      end else if (wr_fire) begin
         idx_q <= last_entry ? '0 : idx_q + 1'b1;   // back to 0 after tail
      end
   end

   //////////////////////////////////////////////////
   // free-list write request
   //////////////////////////////////////////////////
   assign hk_req_valid_o = (state_q == CU_INIT_LIST);
   assign hk_req_op_o    = OP_WRITE;   // hawk only writes here
   assign hk_req_addr_o  = LIST_BASE + ADDR_W'(idx_q) * ADDR_W'(ENTRY_BYTES);

   // next pointer is the following entry index and the tail gets null
   assign hk_req_wdata_o = last_entry ? NULL_PTR : DATA_W'(idx_q) + DATA_W'(1);

   // status decode
   assign hawk_busy_o     = (state_q == CU_IDLE) || (state_q == CU_INIT_LIST);
   assign table_protect_o = (state_q == CU_ACTIVE);
   assign init_done_o     = (state_q == CU_ACTIVE);   // stays until reset

   //////////////////////////////////////////////////
   // checks
   //////////////////////////////////////////////////
   // mux back-pressure must not disturb a pending write
   a_hk_req_stable : assert property (@(posedge clk_i) disable iff (reset_i)
      hk_req_valid_o && !hk_req_ready_i |=>
         hk_req_valid_o && $stable(hk_req_addr_o) && $stable(hk_req_wdata_o)
         && $stable(hk_req_op_o))
      else $error("hawk request changed while stalled");

   // counter parked at zero outside the build
   a_idx_range : assert property (@(posedge clk_i) disable iff (reset_i)
      (state_q != CU_INIT_LIST) |-> (idx_q == '0))
      else $error("entry counter off zero outside the list build");

endmodule

//--- src/hacd_pkg.sv
// hacd core shared definitions
// widths, free-list table layout and the enums used by the
// control unit, the cpu stall gate and the memory mux

package hacd_pkg;

   //////////////////////////////////////////////////
   // bus widths
   //////////////////////////////////////////////////
   localparam int ADDR_W  = 32;   // byte address
   localparam int DATA_W  = 64;   // one reduced cacheline word

   //////////////////////////////////////////////////
   // free-list table region
   //////////////////////////////////////////////////
   localparam logic [ADDR_W-1:0] LIST_BASE = 32'h0000_1000;   // entry 0
   localparam int LIST_ENTRIES = 16;                          // page entries in the list
   localparam int ENTRY_BYTES  = 8;                           // one word per entry

   // first byte past the table, cpu writes below this are guarded
   localparam logic [ADDR_W-1:0] LIST_END =
      LIST_BASE + ADDR_W'(LIST_ENTRIES * ENTRY_BYTES);

   // next pointer of the tail entry
   localparam logic [DATA_W-1:0] NULL_PTR = {DATA_W{1'b1}};

   //////////////////////////////////////////////////
   // counter widths
   //////////////////////////////////////////////////
   localparam int IDX_W   = 4;   // entry index during list build
   localparam int OUTST_W = 4;   // reads in flight toward mc

   // request opcode, same encoding on every channel
   typedef enum logic {
      OP_READ  = 1'b0,
      OP_WRITE = 1'b1
   } mem_op_e;

   // control unit states
   typedef enum logic [1:0] {
      CU_IDLE      = 2'd0,   // just out of reset, sample sw controls
      CU_INIT_LIST = 2'd1,   // writing free-list entries
      CU_ACTIVE    = 2'd2,   // list built, table guarded
      CU_BYPASS    = 2'd3    // hawk inactive, cpu straight through
   } cu_state_e;

endpackage
